/* Bender.yml */
package:
  name: bb1_slice

sources:
  - files:
      - hdl/bb1Pkg.sv
      - hdl/multiportRam.sv
      - hdl/sliceAlu.sv
      - hdl/sliceController.sv
      - hdl/sliceTop.sv
  - target: simulation
    files:
      - verif/sliceTop_properties.sv
      - verif/sliceTb.sv

/* flist.f */
hdl/bb1Pkg.sv
hdl/multiportRam.sv
hdl/sliceAlu.sv
hdl/sliceController.sv
hdl/sliceTop.sv
verif/sliceTop_properties.sv
verif/sliceTb.sv

/* hdl/bb1Pkg.sv */
// --------------------
// Shared definitions for the bit-slice datapath
//   data and address widths
//   register and port counts
//   micro-operation encoding
// --------------------
package bb1Pkg;

    // Slice geometry
    localparam int DataWidth = 4;   // One nibble per slice
    localparam int AddrWidth = 2;   // Selects one of four registers
    localparam int NumRegs   = 4;
    localparam int NumPorts  = 4;   // A, B, C and X in that order

    // Port index into the register file's internal arrays
    localparam int PortA = 0;
    localparam int PortB = 1;
    localparam int PortC = 2;
    localparam int PortX = 3;

    typedef logic [DataWidth-1:0] dataT;     // Every data bus
    typedef logic [AddrWidth-1:0] regAddrT;  // Every register address

    // Micro-operations
    // Count bypasses the ALU and bumps register 0 instead
    typedef enum logic [2:0] {
        OpPass  = 3'd0,   // Result is operand A
        OpAdd   = 3'd1,   // A + B, carry out
        OpSub   = 3'd2,   // A - B, borrow out
        OpAnd   = 3'd3,
        OpOr    = 3'd4,
        OpXor   = 3'd5,
        OpCount = 3'd6    // Register 0 increment
    } aluOpT;

endpackage

/* hdl/multiportRam.sv */
// --------------------
// Four-port 4x4 register file
//   ports A, B, C, X with one-hot select
//   ORed write merge on collisions
//   register 0 counter with carry out
//   register 0 vs register 3 equality flag
// --------------------
`timescale 1ns/1ps

module multiportRam (
    input  logic             clk,
    input  logic             rstN,
    input  bb1Pkg::regAddrT  addrA,
    input  logic             enA,
    input  logic             writeA,
    input  logic             readA,
    input  bb1Pkg::dataT     wrDataA,
    output bb1Pkg::dataT     rdDataA,
    input  bb1Pkg::regAddrT  addrB,
    input  logic             enB,
    input  logic             writeB,
    input  logic             readB,
    input  bb1Pkg::dataT     wrDataB,
    output bb1Pkg::dataT     rdDataB,
    input  bb1Pkg::regAddrT  addrC,
    input  logic             enC,
    input  logic             writeC,
    input  logic             readC,
    input  bb1Pkg::dataT     wrDataC,
    output bb1Pkg::dataT     rdDataC,
    input  bb1Pkg::regAddrT  addrX,
    input  logic             enX,
    input  logic             writeX,
    input  logic             readX,
    input  bb1Pkg::dataT     wrDataX,
    output bb1Pkg::dataT     rdDataX,
    input  logic             countEn,    // Increment register 0
    output logic             carryOut,   // Pulse after 15 -> 0 wrap
    output logic             eqFlag      // Register 0 == register 3
);
    import bb1Pkg::*;

    regAddrT             portAddr   [NumPorts];
    logic [NumPorts-1:0] portEn;
    logic [NumPorts-1:0] portWr;
    logic [NumPorts-1:0] portRd;
    dataT                portWrData [NumPorts];
    dataT                portRdData [NumPorts];
    logic [NumRegs-1:0]  sel        [NumPorts];   // One-hot per port
    logic [NumRegs-1:0]  wrHit;                    // Register written this cycle
    dataT                wrData     [NumRegs];     // Merged write data
    dataT                regs       [NumRegs];

    // Gather the loose ports so every port shares one decoder
    assign portAddr   = '{addrA, addrB, addrC, addrX};
    assign portEn     = {enX, enC, enB, enA};
    assign portWr     = {writeX, writeC, writeB, writeA};
    assign portRd     = {readX, readC, readB, readA};
    assign portWrData = '{wrDataA, wrDataB, wrDataC, wrDataX};

    assign rdDataA = portRdData[PortA];
    assign rdDataB = portRdData[PortB];
    assign rdDataC = portRdData[PortC];
    assign rdDataX = portRdData[PortX];

    for (genvar p = 0; p < NumPorts; p++) begin : genPort
        assign sel[p] = portEn[p] ? (NumRegs'(1) << portAddr[p]) : '0;   // Disabled port selects nothing

        // AND-OR read mux, zero when the port is not reading
        always_comb begin
            portRdData[p] = '0;
            for (int r = 0; r < NumRegs; r++) begin
                portRdData[p] |= {DataWidth{sel[p][r] & portRd[p]}} & regs[r];
            end
        end
    end

    // Several writers on one register are ORed, as on the original chip
    always_comb begin
        for (int r = 0; r < NumRegs; r++) begin
            wrHit[r]  = 1'b0;
            wrData[r] = '0;
            for (int p = 0; p < NumPorts; p++) begin
                wrHit[r]  |= sel[p][r] & portWr[p];
                wrData[r] |= {DataWidth{sel[p][r] & portWr[p]}} & portWrData[p];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int r = 0; r < NumRegs; r++) begin
                regs[r] <= '0;
            end
            carryOut <= 1'b0;
        end else begin
            for (int r = 1; r < NumRegs; r++) begin
                if (wrHit[r]) begin
                    regs[r] <= wrData[r];
                end
            end
            if (wrHit[0]) begin              // Port write beats counting
                regs[0] <= wrData[0];
            end else if (countEn) begin
                regs[0] <= regs[0] + 1'b1;  // Wraps 15 -> 0
            end
            carryOut <= countEn && !wrHit[0] && (&regs[0]);  // High one cycle only
        end
    end

    assign eqFlag = (regs[0] == regs[NumRegs-1]);

endmodule

/* hdl/sliceAlu.sv */
// --------------------
// Slice ALU
//   operand bypass from own result register
//   pass, add, sub and logic ops
//   registered result, carry and zero flags
// --------------------
`timescale 1ns/1ps

module sliceAlu (
    input  logic           clk,
    input  logic           rstN,
    input  bb1Pkg::dataT   opA,        // Port A read data
    input  bb1Pkg::dataT   opB,        // Port B read data
    input  bb1Pkg::aluOpT  aluOp,
    input  logic           fwdA,       // Take A from result register
    input  logic           fwdB,       // Take B from result register
    input  logic           load,       // Register result and flags
    output bb1Pkg::dataT   result,
    output logic           carryFlag,
    output logic           zeroFlag
);
    import bb1Pkg::*;

    dataT               aIn;
    dataT               bIn;
    logic [DataWidth:0] aluOut;   // Top bit is carry or borrow

    // Result register still holds the value not yet written back
    assign aIn = fwdA ? result : opA;
    assign bIn = fwdB ? result : opB;

    always_comb begin
        aluOut = '0;
        case (aluOp)
            OpPass:  aluOut = {1'b0, aIn};
            OpAdd:   aluOut = {1'b0, aIn} + {1'b0, bIn};
            OpSub:   aluOut = {1'b0, aIn} - {1'b0, bIn};   // Borrow lands in top bit
            OpAnd:   aluOut = {1'b0, aIn & bIn};
            OpOr:    aluOut = {1'b0, aIn | bIn};
            OpXor:   aluOut = {1'b0, aIn ^ bIn};
            default: aluOut = {1'b0, aIn};   // Count never loads
        endcase
    end

    always_ff @(posedge clk) begin
        if (load) begin
            result <= aluOut[DataWidth-1:0];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            carryFlag <= 1'b0;
            zeroFlag  <= 1'b0;
        end else if (load) begin
            carryFlag <= aluOut[DataWidth];
            zeroFlag  <= (aluOut[DataWidth-1:0] == '0);
        end
    end

endmodule

/* hdl/sliceController.sv */
// --------------------
// Micro-instruction decode
//   port A/B read strobes, ALU load, count enable
//   one-deep writeback stage on port C
//   bypass selects against pending destination
// --------------------
`timescale 1ns/1ps

module sliceController (
    input  logic             clk,
    input  logic             rstN,
    input  logic             opValid,   // One instruction per high cycle
    input  bb1Pkg::aluOpT    opCode,
    input  bb1Pkg::regAddrT  srcA,
    input  bb1Pkg::regAddrT  srcB,
    input  bb1Pkg::regAddrT  dst,
    output bb1Pkg::regAddrT  addrA,
    output bb1Pkg::regAddrT  addrB,
    output bb1Pkg::regAddrT  addrC,
    output logic             enA,
    output logic             readA,
    output logic             enB,
    output logic             readB,
    output logic             enC,
    output logic             writeC,
    output logic             countEn,
    output logic             aluLoad,
    output logic             fwdA,
    output logic             fwdB,
    output logic             resultValid,
    output bb1Pkg::aluOpT    aluOp
);
    import bb1Pkg::*;

    logic    aluIssue;    // ALU instruction this cycle
    logic    pendValid;   // Result waiting for writeback
    regAddrT pendDst;     // Where it goes

    assign aluIssue = opValid && (opCode != OpCount);
    assign countEn  = opValid && (opCode == OpCount);   // Straight to register 0

    // Operands read in the issue cycle
    assign addrA   = srcA;
    assign addrB   = srcB;
    assign enA     = aluIssue;
    assign readA   = aluIssue;
    assign enB     = aluIssue;
    assign readB   = aluIssue;
    assign aluOp   = opCode;
    assign aluLoad = aluIssue;

    // Previous result not in the file yet, so read it from the ALU
    assign fwdA = aluIssue && pendValid && (srcA == pendDst);
    assign fwdB = aluIssue && pendValid && (srcB == pendDst);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pendValid <= 1'b0;
        end else begin
            pendValid <= aluIssue;   // Count leaves no writeback
        end
    end

    always_ff @(posedge clk) begin
        if (aluIssue) begin
            pendDst <= dst;
        end
    end

    // Writeback one edge after the result is registered
    assign addrC       = pendDst;
    assign enC         = pendValid;
    assign writeC      = pendValid;
    assign resultValid = pendValid;   // Same cycle the result is on show

endmodule

/* hdl/sliceTop.sv */
// --------------------
// Bit-slice top level
//   controller, ALU and register file
//   host port X straight to the file
// --------------------
`timescale 1ns/1ps

module sliceTop (
    input  logic             clk,
    input  logic             rstN,
    input  logic             opValid,
    input  bb1Pkg::aluOpT    opCode,
    input  bb1Pkg::regAddrT  srcA,
    input  bb1Pkg::regAddrT  srcB,
    input  bb1Pkg::regAddrT  dst,
    input  logic             xEn,
    input  logic             xWrite,
    input  logic             xRead,
    input  bb1Pkg::regAddrT  xAddr,
    input  bb1Pkg::dataT     xWrData,
    output bb1Pkg::dataT     xRdData,
    output bb1Pkg::dataT     result,
    output logic             resultValid,
    output logic             carryFlag,
    output logic             zeroFlag,
    output logic             carryOut,
    output logic             eqFlag
);
    import bb1Pkg::*;

    regAddrT addrA, addrB, addrC;
    logic    enA, readA, enB, readB, enC, writeC;
    logic    countEn, aluLoad, fwdA, fwdB;
    aluOpT   aluOp;
    dataT    rdA, rdB;

    sliceController ctrl0 (
        .clk, .rstN, .opValid, .opCode, .srcA, .srcB, .dst,
        .addrA, .addrB, .addrC,
        .enA, .readA, .enB, .readB, .enC, .writeC,
        .countEn, .aluLoad, .fwdA, .fwdB, .resultValid, .aluOp
    );

    sliceAlu alu0 (
        .clk, .rstN,
        .opA (rdA),
        .opB (rdB),
        .aluOp, .fwdA, .fwdB,
        .load (aluLoad),
        .result, .carryFlag, .zeroFlag
    );

    // A and B only read, C only writes
    multiportRam ram0 (
        .clk, .rstN,
        .addrA, .enA, .writeA (1'b0), .readA, .wrDataA ('0), .rdDataA (rdA),
        .addrB, .enB, .writeB (1'b0), .readB, .wrDataB ('0), .rdDataB (rdB),
        .addrC, .enC, .writeC, .readC (1'b0), .wrDataC (result), .rdDataC (),
        .addrX (xAddr), .enX (xEn), .writeX (xWrite), .readX (xRead),
        .wrDataX (xWrData), .rdDataX (xRdData),
        .countEn, .carryOut, .eqFlag
    );

endmodule

/* verif/sliceTb.sv */
// --------------------
// sliceTop testbench
//   reference ALU and shadow register file
//   result checker with compare tasks
//   cycle-count timeout
// --------------------
`timescale 1ns/1ps

module sliceTb;
    import bb1Pkg::*;

    localparam int MaxCycles = 400;   // Tests take under 200 cycles

    logic    clk, rstN, opValid, xEn, xWrite, xRead;
    aluOpT   opCode;
    regAddrT srcA, srcB, dst, xAddr;
    dataT    xWrData, xRdData, result;
    logic    resultValid, carryFlag, zeroFlag, carryOut, eqFlag;
    integer  seed;
    int      cycleCount = 0;
    logic    expValid = 1'b0;           // Result due in this cycle
    dataT    shadow [NumRegs];          // Program view, updated at issue
    logic [DataWidth+1:0] expQ [$];     // Zero, carry, result per ALU issue

    sliceTop dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Carry or borrow in the top bit
    function automatic logic [DataWidth:0] refAlu(aluOpT op, dataT a, dataT b);
        case (op)
            OpAdd:   return {(int'(a) + int'(b)) > 15, dataT'(a + b)};
            OpSub:   return {a < b, dataT'(a - b)};   // Borrow when B is larger
            OpAnd:   return {1'b0, a & b};
            OpOr:    return {1'b0, a | b};
            OpXor:   return {1'b0, a ^ b};
            default: return {1'b0, a};                // Pass
        endcase
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkData(input dataT act, input dataT want, input string what);
        if (act !== want) begin
            abortRun($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                $time, what, act, want));
        end
    endtask

    task automatic checkFlag(input logic act, input logic want, input string what);
        if (act !== want) begin
            abortRun($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
                $time, what, act, want));
        end
    endtask

    task automatic stepCycle();
        @(posedge clk) #5;   // Inputs move 5 ns after the edge
    endtask

    task automatic writeX(input regAddrT addr, input dataT data);
        xEn          = 1'b1;
        xWrite       = 1'b1;
        xAddr        = addr;
        xWrData      = data;
        shadow[addr] = data;
        stepCycle();
        xEn          = 1'b0;
        xWrite       = 1'b0;
    endtask

    // Read data and eqFlag sampled mid-cycle
    task automatic readX(input regAddrT addr, input string what);
        xEn   = 1'b1;
        xRead = 1'b1;
        xAddr = addr;
        @(negedge clk);
        checkData(xRdData, shadow[addr], what);
        checkFlag(eqFlag, shadow[0] == shadow[NumRegs-1], "eqFlag");
        stepCycle();
        xEn   = 1'b0;
        xRead = 1'b0;
    endtask

    task automatic driveOp(aluOpT op, regAddrT a, regAddrT b, regAddrT d);
        logic [DataWidth:0] refOut;
        refOut  = refAlu(op, shadow[a], shadow[b]);
        opValid = 1'b1;
        opCode  = op;
        srcA    = a;
        srcB    = b;
        dst     = d;
        if (op == OpCount) begin
            shadow[0] = shadow[0] + 1'b1;   // Counter only, no writeback
        end else begin
            expQ.push_back({refOut[DataWidth-1:0] == '0, refOut});
            shadow[d] = refOut[DataWidth-1:0];
        end
    endtask

    // resultValid, result and flags in the cycle after issue
    always @(posedge clk) expValid <= rstN && opValid && (opCode != OpCount);

    always @(negedge clk) begin : checkResult
        logic [DataWidth+1:0] want;
        if (rstN) begin
            checkFlag(resultValid, expValid, "resultValid");
            if (expValid) begin
                want = expQ.pop_front();
                checkData(result, want[DataWidth-1:0], "result");
                checkFlag(carryFlag, want[DataWidth], "carryFlag");
                checkFlag(zeroFlag, want[DataWidth+1], "zeroFlag");
            end
        end
    end

    // Bound assertions fire at the rising edge, seen here half a cycle later
    always @(negedge clk) begin
        if (dut0.props0.failCount != 0) begin
            abortRun("An assertion on the sliceTop ports failed");
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > MaxCycles) begin
            abortRun($sformatf("Timeout: run still going after %0d cycles", MaxCycles));
        end
    end

    initial begin
        regAddrT a, d;
        logic    prevWrap, expWrap, expEq;
        seed   = 75;
        rstN   = 1'b0;
        opCode = OpPass;
        {opValid, xEn, xWrite, xRead} = '0;
        {srcA, srcB, dst, xAddr, xWrData} = '0;
        shadow = '{default: '0};
        repeat (2) @(posedge clk);
        #5 rstN = 1'b1;

        @(negedge clk);
        checkFlag(carryOut, 1'b0, "carryOut after reset");
        stepCycle();
        for (int r = 0; r < NumRegs; r++) readX(regAddrT'(r), "register after reset");

        // Host writes, then one forced match of registers 0 and 3
        repeat (8) begin
            a = regAddrT'($random(seed));
            writeX(a, dataT'($random(seed)));
            readX(a, "port X readback");
        end
        writeX(2'd3, shadow[0]);
        readX(2'd3, "port X readback");

        // Each ALU opcode, destination read back after writeback
        repeat (2) begin
            for (int k = 0; k < 6; k++) begin
                a = regAddrT'($random(seed));
                d = regAddrT'($random(seed));
                driveOp(aluOpT'(k), a, regAddrT'($random(seed)), d);
                stepCycle();       // Edge 0, result registered
                opValid = 1'b0;
                stepCycle();       // Edge 1, written back
                readX(d, "result in destination");
            end
        end

        // Dependent chain through the bypass
        d = 2'd1;
        repeat (8) begin
            a = d;
            d = regAddrT'($random(seed));
            driveOp(aluOpT'($unsigned($random(seed)) % 6), a, regAddrT'($random(seed)), d);
            stepCycle();
        end
        opValid = 1'b0;
        stepCycle();
        for (int r = 0; r < NumRegs; r++) readX(regAddrT'(r), "register after chain");

        // Count 13 to 1 through the wrap, register 3 held at 15
        writeX(2'd0, 4'd13);
        writeX(2'd3, 4'd15);
        prevWrap = 1'b0;
        for (int i = 0; i <= 4; i++) begin
            expEq   = (shadow[0] == shadow[3]);   // State after previous count
            expWrap = prevWrap;
            if (i < 4) begin
                prevWrap = (shadow[0] == 4'hF);
                driveOp(OpCount, '0, '0, '0);
            end else begin
                opValid = 1'b0;
            end
            @(negedge clk);
            checkFlag(carryOut, expWrap, "carryOut while counting");
            checkFlag(eqFlag, expEq, "eqFlag while counting");
            stepCycle();
        end
        readX(2'd0, "register 0 after counting");

        if (dut0.props0.failCount != 0) begin
            abortRun("An assertion on the sliceTop ports failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* verif/sliceTop_properties.sv */
// --------------------
// Concurrent assertions on sliceTop ports
//   carryOut pulse width, resultValid timing
//   eqFlag under reset
// --------------------
`timescale 1ns/1ps

module sliceTop_properties (
    input logic           clk,
    input logic           rstN,
    input logic           opValid,
    input bb1Pkg::aluOpT  opCode,
    input logic           resultValid,
    input logic           carryOut,
    input logic           eqFlag
);
    import bb1Pkg::*;

    int failCount = 0;   // Polled by the testbench

    carryOnce: assert property (@(posedge clk) disable iff (!rstN) carryOut |=> !carryOut)
        else begin
            $error("carryOut high two cycles in a row");
            failCount++;
        end

    // Exactly one cycle after a non-Count issue
    validTiming: assert property (@(posedge clk) disable iff (!rstN)
        resultValid == $past(opValid && (opCode != OpCount)))
        else begin
            $error("resultValid out of step with issue");
            failCount++;
        end

    eqInReset: assert property (@(posedge clk) !rstN |-> eqFlag)
        else begin
            $error("eqFlag low during reset");
            failCount++;
        end

endmodule

bind sliceTop sliceTop_properties props0 (
    .clk, .rstN, .opValid, .opCode, .resultValid, .carryOut, .eqFlag
);
